/* Makefile */
# Verilator build and run of the pipelined Baugh-Wooley multiplier

VERILATOR  ?= verilator
TOP        := tb_bw_mul
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log decides, a crash without a result also counts as failure
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation gave no result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
verilog/bw_pkg.sv
verilog/bw_row.sv
verilog/bw_array.sv
verilog/bw_final_adder.sv
verilog/bw_mul.sv
tests/tb_bw_mul.sv

/* tests/tb_bw_mul.sv */
`timescale 1ns/1ps

module tb_bw_mul
	import bw_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int N_RANDOM = 2000;
	localparam int N_GAPPY = 800;
	localparam int N_AFTER_RST = 100;
	localparam int DRAIN_LIMIT = 10;

	// all phases plus drains and the reset phase
	localparam int TEST_CYCLES = 3 + 10 + 25 + N_RANDOM + N_GAPPY + N_AFTER_RST + 100;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 1000;

	// one expected product and the cycle it must show up in
	typedef struct packed {
		product_t    value;
		int unsigned due;
	} expect_t;

	logic      clk;
	logic      rst;
	logic      in_valid;
	operands_t operands;
	logic      out_valid;
	product_t  product;

	logic [31:0] rng_state;
	int unsigned cyc = 0;
	int          value_errors;
	int          protocol_errors;
	int          checked;
	expect_t     exp_q[$];

	bw_mul dut_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.operands  (operands),
		.out_valid (out_valid),
		.product   (product)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// rising edges seen so far
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	//////////////////////////////////////////////////////////////
	// stimulus and model
	//////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper bits of the lcg are the better ones
	function automatic logic [OP_W-1:0] random_word();
		logic [31:0] r;
		r = lcg_next();
		return r[31:32-OP_W];
	endfunction

	function automatic operands_t random_pair();
		operands_t op;
		op.a = random_word();
		op.b = random_word();
		return op;
	endfunction

	function automatic product_t model_product(operands_t op);
		product_t wa;
		product_t wb;
		wa = {{OP_W{op.a[OP_W-1]}}, op.a};
		wb = {{OP_W{op.b[OP_W-1]}}, op.b};
		return wa * wb;
	endfunction

	//////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////

	// runs at the falling edge when outputs are stable
	task automatic check_outputs();
		expect_t exp;
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("out_valid high at cycle %0d with no product expected", cyc);
				protocol_errors++;
			end else begin
				exp = exp_q.pop_front();
				checked++;
				if (exp.due != cyc) begin
					$display("product came at cycle %0d but was due at cycle %0d",
						cyc, exp.due);
					protocol_errors++;
				end
				if (product !== exp.value) begin
					$display("ERR product expected %h actual %h", exp.value, product);
					value_errors++;
				end
			end
		end else if (out_valid !== 1'b0) begin
			$display("out_valid is unknown at cycle %0d", cyc);
			protocol_errors++;
		end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
			$display("out_valid missing at cycle %0d for a pending product", cyc);
			protocol_errors++;
			void'(exp_q.pop_front());
		end
	endtask

	// check what came out and drive the next input
	task automatic drive_cycle(input logic valid, input operands_t op);
		expect_t exp;
		@(negedge clk);
		check_outputs();
		in_valid = valid;
		operands = op;
		if (valid) begin
			exp.value = model_product(op);
			exp.due = cyc + 2;
			exp_q.push_back(exp);
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			drive_cycle(1'b0, '0);
			n++;
		end
	endtask

	task automatic send_corners();
		logic [OP_W-1:0] corners [5];
		operands_t op;
		corners[0] = '0;
		corners[1] = {{(OP_W-1){1'b0}}, 1'b1};
		corners[2] = '1;
		corners[3] = {1'b0, {(OP_W-1){1'b1}}};
		corners[4] = {1'b1, {(OP_W-1){1'b0}}};
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				op.a = corners[i];
				op.b = corners[j];
				drive_cycle(1'b1, op);
			end
		end
	endtask

	// one item in stage one and one at the input get lost
	task automatic reset_in_flight();
		for (int k = 0; k < 3; k++) begin
			drive_cycle(1'b1, random_pair());
		end
		@(negedge clk);
		check_outputs();
		rst = 1'b1;
		in_valid = 1'b1;
		operands = random_pair();
		exp_q.delete();
		repeat (2) begin
			@(negedge clk);
			check_outputs();
			in_valid = 1'b0;
		end
		rst = 1'b0;
		if (out_valid !== 1'b0) begin
			$display("out_valid not low after reset with items in flight");
			protocol_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		rng_state = 32'h7c478a39;
		value_errors = 0;
		protocol_errors = 0;
		checked = 0;
		rst = 1'b1;
		in_valid = 1'b0;
		operands = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		if (out_valid !== 1'b0) begin
			$display("out_valid not low after the initial reset");
			protocol_errors++;
		end

		// idle cycles with nothing coming out
		repeat (10) drive_cycle(1'b0, '0);

		send_corners();
		drain();

		// back to back with one product per cycle
		for (int i = 0; i < N_RANDOM; i++) begin
			drive_cycle(1'b1, random_pair());
		end
		drain();

		// random gaps in in_valid with about three in four cycles busy
		for (int i = 0; i < N_GAPPY; i++) begin
			r = lcg_next();
			drive_cycle(r[20:19] != 2'b00, random_pair());
		end
		drain();

		reset_in_flight();
		for (int i = 0; i < N_AFTER_RST; i++) begin
			r = lcg_next();
			drive_cycle(r[20:19] != 2'b00, random_pair());
		end
		drain();

		if (exp_q.size() != 0) begin
			$display("expected products left over at the end of the run");
			protocol_errors++;
		end

		$display("errors: %0d value, %0d protocol, %0d products checked",
			value_errors, protocol_errors, checked);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("errors: %0d value, %0d protocol, %0d products checked",
			value_errors, protocol_errors, checked);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* verilog/bw_array.sv */
`timescale 1ns/1ps

module bw_array
	import bw_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  operands_t operands,
	output logic      part_valid,
	output partial_t  partial
);

	// sum and carry between rows, index r feeds row r
	logic [OP_W-1:0] sum_chain   [OP_W+1];
	logic [OP_W-1:0] carry_chain [OP_W+1];

	// one retired product bit per row
	logic [OP_W-1:0] low_bits;

	// combinational array result, before stage one
	partial_t partial_next;

	//////////////////////////////////////////////////////////////
	// carry-save array
	//////////////////////////////////////////////////////////////

	// first row adds into nothing
	assign sum_chain[0] = '0;
	assign carry_chain[0] = '0;

	for (genvar r = 0; r < OP_W; r++) begin : g_row
		bw_row #(
			.ROW(r)
		) row_i (
			.a         (operands.a),
			.b_bit     (operands.b[r]),
			.sum_in    (sum_chain[r]),
			.carry_in  (carry_chain[r]),
			.sum_out   (sum_chain[r+1]),
			.carry_out (carry_chain[r+1]),
			.low_bit   (low_bits[r])
		);
	end

	// after the last row sum and carry both start at weight OP_W
	always_comb begin
		partial_next.low = low_bits;
		partial_next.sum = sum_chain[OP_W];
		partial_next.carry = carry_chain[OP_W];
	end

	//////////////////////////////////////////////////////////////
	// stage one
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			part_valid <= 1'b0;
		end else begin
			part_valid <= in_valid;
		end
	end

	// hold the last result while idle
	always_ff @(posedge clk) begin
		if (in_valid) begin
			partial <= partial_next;
		end
	end

	//////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////

	// in-flight items are dropped by reset
	a_rst_clears_valid: assert property (
		@(posedge clk) rst |=> !part_valid
	) else $error("part_valid high in the cycle after rst");

endmodule

/* verilog/bw_final_adder.sv */
`timescale 1ns/1ps

module bw_final_adder
	import bw_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     part_valid,
	input  partial_t partial,
	output logic     out_valid,
	output product_t product
);

	// ripple carries, rc[j] enters bit j
	logic [OP_W-1:0] rc;

	// upper half before and after the msb correction
	logic [OP_W-1:0] upper_raw;
	logic [OP_W-1:0] upper;

	//////////////////////////////////////////////////////////////
	// ripple merge
	//////////////////////////////////////////////////////////////

	// correction bit OP_W goes in as the carry into the chain
	assign rc[0] = BW_CORRECTION[OP_W];

	for (genvar j = 0; j < OP_W; j++) begin : g_fa
		assign upper_raw[j] = partial.sum[j] ^ partial.carry[j] ^ rc[j];

		// carry out of the top bit falls off the product
		if (j < OP_W - 1) begin : g_carry
			assign rc[j+1] = (partial.sum[j] & partial.carry[j]) |
				(partial.sum[j] & rc[j]) |
				(partial.carry[j] & rc[j]);
		end
	end

	// the correction bit at the msb only flips it,
	// its carry is outside the product
	assign upper = {upper_raw[OP_W-1] ^ BW_CORRECTION[PROD_W-1],
		upper_raw[OP_W-2:0]};

	//////////////////////////////////////////////////////////////
	// stage two
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= part_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (part_valid) begin
			product <= {upper, partial.low};
		end
	end

	//////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////

	// an X here means an operand bit was never driven upstream
	a_product_known: assert property (
		@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(product)
	) else $error("product has unknown bits while out_valid");

endmodule

/* verilog/bw_mul.sv */
`timescale 1ns/1ps

module bw_mul
	import bw_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  operands_t operands,
	output logic      out_valid,
	output product_t  product
);

	//////////////////////////////////////////////////////////////
	// between the stages
	//////////////////////////////////////////////////////////////

	logic part_valid;

	// low half done, upper half still in carry-save form
	partial_t partial;

	//////////////////////////////////////////////////////////////
	// stage one, partial products and carry-save rows
	//////////////////////////////////////////////////////////////

	bw_array array_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.operands   (operands),
		.part_valid (part_valid),
		.partial    (partial)
	);

	//////////////////////////////////////////////////////////////
	// stage two, ripple merge and sign correction
	//////////////////////////////////////////////////////////////

	bw_final_adder final_i (
		.clk        (clk),
		.rst        (rst),
		.part_valid (part_valid),
		.partial    (partial),
		.out_valid  (out_valid),
		.product    (product)
	);

endmodule

/* verilog/bw_pkg.sv */
package bw_pkg;

	//////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////

	// operand width, both inputs
	localparam int OP_W = 16;

	// full signed product
	localparam int PROD_W = 2 * OP_W;

	//////////////////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////////////////

	typedef struct packed {
		logic signed [OP_W-1:0] a;
		logic signed [OP_W-1:0] b;
	} operands_t;

	// carry-save array output, upper half still unmerged
	typedef struct packed {
		logic [OP_W-1:0] low;
		logic [OP_W-1:0] sum;
		logic [OP_W-1:0] carry;
	} partial_t;

	typedef logic signed [PROD_W-1:0] product_t;

	// sign correction, ones at bit OP_W and at the product msb
	localparam logic [PROD_W-1:0] BW_CORRECTION =
		(PROD_W'(1) << (PROD_W - 1)) | (PROD_W'(1) << OP_W);

endpackage

/* verilog/bw_row.sv */
`timescale 1ns/1ps

module bw_row
	import bw_pkg::*;
#(
	parameter int ROW = 0
) (
	input  logic signed [OP_W-1:0] a,
	input  logic                   b_bit,
	input  logic        [OP_W-1:0] sum_in,
	input  logic        [OP_W-1:0] carry_in,
	output logic        [OP_W-1:0] sum_out,
	output logic        [OP_W-1:0] carry_out,
	output logic                   low_bit
);

	// this row holds the sign bit of b
	localparam bit SIGN_ROW = (ROW == OP_W - 1);

	// partial product terms, after sign inversion
	logic [OP_W-1:0] pp;

	// cell outputs, sum at weight ROW+j, carry at ROW+j+1
	logic [OP_W-1:0] cell_sum;
	logic [OP_W-1:0] cell_carry;

	//////////////////////////////////////////////////////////////
	// cells
	//////////////////////////////////////////////////////////////

	for (genvar j = 0; j < OP_W; j++) begin : g_cell

		// sign column of a
		localparam bit SIGN_COL = (j == OP_W - 1);

		// nand-type where exactly one of the two bits is a sign bit,
		// and-type everywhere else (a15*b15 included)
		if (SIGN_COL != SIGN_ROW) begin : g_nand
			assign pp[j] = ~(a[j] & b_bit);
		end else begin : g_and
			assign pp[j] = a[j] & b_bit;
		end

		// full adder
		assign cell_sum[j] = pp[j] ^ sum_in[j] ^ carry_in[j];
		assign cell_carry[j] = (pp[j] & sum_in[j]) |
			(pp[j] & carry_in[j]) |
			(sum_in[j] & carry_in[j]);

	end

	//////////////////////////////////////////////////////////////
	// row outputs
	//////////////////////////////////////////////////////////////

	// lowest sum bit is final, retire it
	assign low_bit = cell_sum[0];

	// sum moves down one place to line up with the next row;
	// nothing lands at the top weight
	assign sum_out = {1'b0, cell_sum[OP_W-1:1]};

	// carries already sit at the next row's weights
	assign carry_out = cell_carry;

endmodule
